//--- common/tpm_mgmt_pkg.sv
// Holds only the TPM 2.0 encodings this block decodes, and response codes are full 32-bit values
`default_nettype none

package tpm_mgmt_pkg;

	//////////////////////////////////////////////////////////////////////
	// Device state and startup encodings

	typedef enum logic [2:0] {
		power_off      = 3'd0,	// Entered from reset and left on the first step
		initialization = 3'd1,
		startup        = 3'd2,
		operational    = 3'd3,
		self_test      = 3'd4,
		failure_mode   = 3'd5,	// Absorbing state
		shutdown       = 3'd6
	} op_state_e;

	typedef enum logic [2:0] {
		su_done    = 3'd0,	// No startup in progress
		su_reset   = 3'd1,
		su_restart = 3'd2,
		su_resume  = 3'd3,
		su_invalid = 3'd4	// State startup after a disorderly shutdown
	} startup_type_e;

	// Result of a hierarchy control command, handed on to the response code register
	typedef enum logic [1:0] {
		hc_none        = 2'd0,
		hc_success     = 2'd1,
		hc_value_error = 2'd2,	// Platform tried to set its own enable
		hc_auth_error  = 2'd3	// Owner or endorsement went beyond clearing its own enable
	} hc_verdict_e;

	typedef logic [15:0] tpm_cc_t;
	typedef logic [31:0] tpm_rc_t;
	typedef logic [31:0] tpm_handle_t;

	//////////////////////////////////////////////////////////////////////
	// Command codes, response codes and handles

	localparam tpm_cc_t cc_hierarchy_control     = 16'h0121;
	localparam tpm_cc_t cc_incremental_self_test = 16'h0142;
	localparam tpm_cc_t cc_self_test             = 16'h0143;
	localparam tpm_cc_t cc_startup               = 16'h0144;
	localparam tpm_cc_t cc_shutdown              = 16'h0145;
	localparam tpm_cc_t cc_get_capability        = 16'h017A;
	localparam tpm_cc_t cc_get_test_result       = 16'h017C;

	localparam tpm_rc_t rc_success   = 32'h0000_0000;
	localparam tpm_rc_t rc_initialize = 32'h0000_0100;	// Format zero base plus zero
	localparam tpm_rc_t rc_failure   = 32'h0000_0101;
	localparam tpm_rc_t rc_auth_type = 32'h0000_0124;
	localparam tpm_rc_t rc_value     = 32'h0000_0084;	// Format one base plus four

	localparam tpm_handle_t rh_owner       = 32'h4000_0001;
	localparam tpm_handle_t rh_endorsement = 32'h4000_000B;
	localparam tpm_handle_t rh_platform    = 32'h4000_000C;
	localparam tpm_handle_t rh_platform_nv = 32'h4000_000D;

	// Startup and shutdown parameter values
	localparam logic [15:0] su_clear = 16'd0;
	localparam logic [15:0] su_state = 16'd1;

	localparam logic [7:0] locality_zero = 8'b0000_0001;	// One-hot locality encoding

	localparam int default_test_count_width = 16;

endpackage

`default_nettype wire

//--- hierarchy/hierarchy_control.sv
// Judges hierarchy control from arguments latched one step earlier, and commands count only at locality zero
`timescale 1ns/1ps
`default_nettype none

module hierarchy_control (
	input  logic                        clock,
	input  logic                        reset_n,
	input  logic                        key_start_n,
	input  tpm_mgmt_pkg::op_state_e     op_state,
	input  tpm_mgmt_pkg::startup_type_e startup_type,
	input  tpm_mgmt_pkg::tpm_cc_t       tpm_cc,
	input  logic [7:0]                  locality,
	input  tpm_mgmt_pkg::tpm_handle_t   auth_hierarchy,
	input  tpm_mgmt_pkg::tpm_handle_t   enable_arg,	// Handle of the enable to change
	input  logic                        yes_no,	// One sets the enable, zero clears it
	input  logic                        nv_ph_enable_nv,
	input  logic                        nv_sh_enable,
	input  logic                        nv_eh_enable,
	output logic                        ph_enable,
	output logic                        ph_enable_nv,
	output logic                        sh_enable,
	output logic                        eh_enable,
	output tpm_mgmt_pkg::hc_verdict_e   hc_verdict
);
	import tpm_mgmt_pkg::*;

	tpm_handle_t auth_q;	// Authorizing hierarchy of the last operational step
	tpm_handle_t enable_q;
	logic        yes_no_q;

	//////////////////////////////////////////////////////////////////////
	// Authorization verdict

	always_comb begin
		hc_verdict = hc_none;
		if (op_state == operational && tpm_cc == cc_hierarchy_control &&
				locality == locality_zero) begin
			case (auth_q)
				rh_platform: begin
					// Platform may change any enable but can only clear its own
					if (enable_q inside {rh_endorsement, rh_owner, rh_platform_nv} ||
							(enable_q == rh_platform && !yes_no_q))
						hc_verdict = hc_success;
					else
						hc_verdict = hc_value_error;
				end
				rh_owner, rh_endorsement: begin
					// Owner and endorsement may only clear their own enable
					if (enable_q == auth_q && !yes_no_q)
						hc_verdict = hc_success;
					else
						hc_verdict = hc_auth_error;
				end
				default: begin
					hc_verdict = hc_none;	// Not a hierarchy authority
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Enable registers

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			ph_enable    <= 1'b0;
			ph_enable_nv <= 1'b0;
			sh_enable    <= 1'b0;
			eh_enable    <= 1'b0;
			auth_q       <= '0;	// Zero matches no authority, so no verdict before a latch
			enable_q     <= '0;
			yes_no_q     <= 1'b0;
		end else if (!key_start_n) begin
			if (op_state == startup && startup_type inside {su_reset, su_restart, su_resume}) begin
				ph_enable <= 1'b1;	// Every valid startup enables the platform
				if (startup_type == su_resume) begin
					ph_enable_nv <= nv_ph_enable_nv;	// Resume restores the saved switches
					sh_enable    <= nv_sh_enable;
					eh_enable    <= nv_eh_enable;
				end else begin
					ph_enable_nv <= 1'b1;
					sh_enable    <= 1'b1;
					eh_enable    <= 1'b1;
				end
			end else if (op_state == operational) begin
				auth_q   <= auth_hierarchy;
				enable_q <= enable_arg;
				yes_no_q <= yes_no;
				// A success verdict has already checked authority against the target
				if (hc_verdict == hc_success) begin
					case (enable_q)
						rh_endorsement: eh_enable    <= yes_no_q;
						rh_owner:       sh_enable    <= yes_no_q;
						rh_platform_nv: ph_enable_nv <= yes_no_q;
						rh_platform:    ph_enable    <= yes_no_q;	// Always a clear here
						default:        ;
					endcase
				end
			end
		end
	end

	// The platform enable is only ever turned on by a startup step
	a_ph_rise_in_startup: assert property (@(posedge clock) disable iff (!reset_n)
		$rose(ph_enable) |-> $past(op_state) == startup);

endmodule

`default_nettype wire

//--- hw/op_state_fsm.sv
// Decides from counts registered one step earlier, and any code outside the seven states goes to failure mode
`timescale 1ns/1ps
`default_nettype none

module op_state_fsm #(
	parameter int test_count_width = tpm_mgmt_pkg::default_test_count_width
) (
	input  logic                          clock,
	input  logic                          reset_n,
	input  logic                          key_start_n,
	input  tpm_mgmt_pkg::tpm_cc_t         tpm_cc,
	input  logic                          initialized,
	input  logic [test_count_width-1:0]   tests_run,
	input  logic [test_count_width-1:0]   tests_passed,
	input  logic [test_count_width-1:0]   untested,
	input  tpm_mgmt_pkg::startup_type_e   startup_type,
	output tpm_mgmt_pkg::op_state_e       op_state,
	output logic                          initialized_q
);
	import tpm_mgmt_pkg::*;

	logic [test_count_width-1:0] tests_run_q;
	logic [test_count_width-1:0] tests_passed_q;
	logic [test_count_width-1:0] untested_q;
	op_state_e                   op_state_next;

	//////////////////////////////////////////////////////////////////////
	// State and input registers

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			op_state       <= power_off;
			initialized_q  <= 1'b0;
			tests_run_q    <= '0;
			tests_passed_q <= '0;
			untested_q     <= '0;
		end else if (!key_start_n) begin
			op_state       <= op_state_next;
			initialized_q  <= initialized;	// Execution engine flag, sampled every step
			tests_run_q    <= tests_run;
			tests_passed_q <= tests_passed;
			untested_q     <= untested;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Next state

	always_comb begin
		op_state_next = op_state;	// Hold unless a rule below moves it
		case (op_state)
			power_off: begin
				op_state_next = initialization;
			end
			initialization: begin
				if (tpm_cc == cc_startup)
					op_state_next = startup;	// Only the startup command leaves here
			end
			startup: begin
				// Initialization done wins over a bad startup request
				if (initialized_q)
					op_state_next = operational;
				else if (startup_type == su_invalid)
					op_state_next = initialization;	// Host must retry with a clear startup
			end
			operational: begin
				if (tpm_cc == cc_self_test || tpm_cc == cc_incremental_self_test)
					op_state_next = self_test;
				else if (tpm_cc == cc_shutdown)
					op_state_next = shutdown;
			end
			self_test: begin
				// A single failed test ends in failure mode
				if (tests_passed_q != tests_run_q)
					op_state_next = failure_mode;
				else if (untested_q == '0)
					op_state_next = operational;	// Every algorithm tested and passed
			end
			failure_mode: begin
				op_state_next = failure_mode;
			end
			shutdown: begin
				op_state_next = operational;
			end
			default: begin
				op_state_next = failure_mode;	// Corrupted state register
			end
		endcase
	end

	// The state register only ever carries one of the seven defined codes
	a_state_legal: assert property (@(posedge clock) disable iff (!reset_n)
		op_state inside {power_off, initialization, startup, operational,
			self_test, failure_mode, shutdown});

	// Only reset takes the device out of failure mode
	a_failure_sticky: assert property (@(posedge clock) disable iff (!reset_n)
		op_state == failure_mode |=> op_state == failure_mode);

endmodule

`default_nettype wire

//--- hw/startup_decoder.sv
// Parameters are registered every step and the type is decoded from them only while in startup
`timescale 1ns/1ps
`default_nettype none

module startup_decoder (
	input  logic                        clock,
	input  logic                        reset_n,
	input  logic                        key_start_n,
	input  tpm_mgmt_pkg::op_state_e     op_state,
	input  logic [15:0]                 startup_param,	// Low half of cmd_param
	input  logic [15:0]                 orderly_input,
	output tpm_mgmt_pkg::startup_type_e startup_type
);
	import tpm_mgmt_pkg::*;

	logic [15:0]   startup_param_q;
	logic [15:0]   orderly_q;
	startup_type_e startup_type_next;

	always_ff @(posedge clock) begin
		if (!key_start_n) begin
			startup_param_q <= startup_param;
			orderly_q       <= orderly_input;
		end
	end

	// Only an orderly state shutdown allows a resume
	always_comb begin
		if (op_state != startup)
			startup_type_next = su_done;
		else if (orderly_q == su_state)
			startup_type_next = (startup_param_q == su_state) ? su_resume : su_restart;
		else
			startup_type_next = (startup_param_q == su_state) ? su_invalid : su_reset;
	end

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n)
			startup_type <= su_done;
		else if (!key_start_n)
			startup_type <= startup_type_next;
	end

	// A type other than done lasts no further than the state that follows startup
	a_done_outside_startup: assert property (@(posedge clock) disable iff (!reset_n)
		startup_type != su_done |-> op_state inside {startup, initialization, operational});

endmodule

`default_nettype wire

//--- hw/response_code_select.sv
// The response code holds its last value in states with no rule, and self test compares the raw counts
`timescale 1ns/1ps
`default_nettype none

module response_code_select #(
	parameter int test_count_width = tpm_mgmt_pkg::default_test_count_width
) (
	input  logic                          clock,
	input  logic                          reset_n,
	input  logic                          key_start_n,
	input  tpm_mgmt_pkg::op_state_e       op_state,
	input  tpm_mgmt_pkg::startup_type_e   startup_type,
	input  tpm_mgmt_pkg::hc_verdict_e     hc_verdict,
	input  tpm_mgmt_pkg::tpm_cc_t         tpm_cc,
	input  tpm_mgmt_pkg::tpm_rc_t         execution_rc,
	input  logic                          initialized_q,	// Registered in the state controller
	input  logic [test_count_width-1:0]   tests_run,
	input  logic [test_count_width-1:0]   tests_passed,
	input  logic [15:0]                   shutdown_param,
	output tpm_mgmt_pkg::tpm_rc_t         tpm_rc,
	output logic [15:0]                   shutdown_save
);
	import tpm_mgmt_pkg::*;

	tpm_rc_t rc_next;

	//////////////////////////////////////////////////////////////////////
	// Response code per state

	always_comb begin
		rc_next = tpm_rc;
		case (op_state)
			initialization: begin
				if (tpm_cc != cc_startup)
					rc_next = rc_initialize;	// Nothing but startup is accepted yet
			end
			startup: begin
				if (initialized_q)
					rc_next = rc_success;
				else if (startup_type == su_invalid)
					rc_next = rc_value;
			end
			operational: begin
				// The execution engine answers every command that is not hierarchy control
				case (hc_verdict)
					hc_success:     rc_next = rc_success;
					hc_value_error: rc_next = rc_value;
					hc_auth_error:  rc_next = rc_auth_type;
					default:        rc_next = execution_rc;
				endcase
			end
			self_test: begin
				rc_next = (tests_passed != tests_run) ? rc_failure : execution_rc;
			end
			failure_mode: begin
				// Only test result and capability queries still run
				if (tpm_cc == cc_get_test_result || tpm_cc == cc_get_capability)
					rc_next = execution_rc;
				else
					rc_next = rc_failure;
			end
			default: begin
				rc_next = tpm_rc;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Registers

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			tpm_rc        <= rc_success;
			shutdown_save <= su_clear;
		end else if (!key_start_n) begin
			tpm_rc <= rc_next;
			if (op_state == shutdown)
				shutdown_save <= shutdown_param;	// Read back as orderly state on the next power up
		end
	end

endmodule

`default_nettype wire

//--- hw/tpm_management.sv
// All state advances only on clock edges with key_start_n low, and cmd_param carries the low 33 bits
`timescale 1ns/1ps
`default_nettype none

module tpm_management #(
	parameter int test_count_width = tpm_mgmt_pkg::default_test_count_width
) (
	input  logic                          clock,
	input  logic                          reset_n,
	input  logic                          key_start_n,	// Step strobe, active low
	input  tpm_mgmt_pkg::tpm_cc_t         tpm_cc,
	input  logic [32:0]                   cmd_param,
	input  logic [15:0]                   orderly_input,	// Saved state of the last shutdown
	input  logic                          initialized,
	input  tpm_mgmt_pkg::tpm_handle_t     auth_hierarchy,
	input  tpm_mgmt_pkg::tpm_rc_t         execution_rc,
	input  logic [7:0]                    locality,
	input  logic [test_count_width-1:0]   tests_run,
	input  logic [test_count_width-1:0]   tests_passed,
	input  logic [test_count_width-1:0]   untested,
	input  logic                          nv_ph_enable_nv,
	input  logic                          nv_sh_enable,
	input  logic                          nv_eh_enable,
	output tpm_mgmt_pkg::op_state_e       op_state,
	output tpm_mgmt_pkg::startup_type_e   startup_type,
	output tpm_mgmt_pkg::tpm_rc_t         tpm_rc,
	output logic                          ph_enable,
	output logic                          ph_enable_nv,
	output logic                          sh_enable,
	output logic                          eh_enable,
	output logic [15:0]                   shutdown_save
);
	import tpm_mgmt_pkg::*;

	logic        initialized_q;	// Registered initialized, shared with the response code logic
	hc_verdict_e hc_verdict;

	//////////////////////////////////////////////////////////////////////
	// Control

	op_state_fsm #(
		.test_count_width(test_count_width)
	) u_op_state_fsm (
		.clock        (clock),
		.reset_n      (reset_n),
		.key_start_n  (key_start_n),
		.tpm_cc       (tpm_cc),
		.initialized  (initialized),
		.tests_run    (tests_run),
		.tests_passed (tests_passed),
		.untested     (untested),
		.startup_type (startup_type),
		.op_state     (op_state),
		.initialized_q(initialized_q)
	);

	//////////////////////////////////////////////////////////////////////
	// Datapath blocks

	startup_decoder u_startup_decoder (
		.clock        (clock),
		.reset_n      (reset_n),
		.key_start_n  (key_start_n),
		.op_state     (op_state),
		.startup_param(cmd_param[15:0]),
		.orderly_input(orderly_input),
		.startup_type (startup_type)
	);

	// The enable handle sits above the yes/no bit in cmd_param
	hierarchy_control u_hierarchy_control (
		.clock          (clock),
		.reset_n        (reset_n),
		.key_start_n    (key_start_n),
		.op_state       (op_state),
		.startup_type   (startup_type),
		.tpm_cc         (tpm_cc),
		.locality       (locality),
		.auth_hierarchy (auth_hierarchy),
		.enable_arg     (cmd_param[32:1]),
		.yes_no         (cmd_param[0]),
		.nv_ph_enable_nv(nv_ph_enable_nv),
		.nv_sh_enable   (nv_sh_enable),
		.nv_eh_enable   (nv_eh_enable),
		.ph_enable      (ph_enable),
		.ph_enable_nv   (ph_enable_nv),
		.sh_enable      (sh_enable),
		.eh_enable      (eh_enable),
		.hc_verdict     (hc_verdict)
	);

	response_code_select #(
		.test_count_width(test_count_width)
	) u_response_code_select (
		.clock         (clock),
		.reset_n       (reset_n),
		.key_start_n   (key_start_n),
		.op_state      (op_state),
		.startup_type  (startup_type),
		.hc_verdict    (hc_verdict),
		.tpm_cc        (tpm_cc),
		.execution_rc  (execution_rc),
		.initialized_q (initialized_q),
		.tests_run     (tests_run),
		.tests_passed  (tests_passed),
		.shutdown_param(cmd_param[15:0]),
		.tpm_rc        (tpm_rc),
		.shutdown_save (shutdown_save)
	);

endmodule

`default_nettype wire

//--- verification/tpm_management_tb.sv
// Checks every output once per clock against a shadow model and uses 16-bit test counts only
`timescale 1ns/1ps
`default_nettype none

module tpm_management_tb;
	import tpm_mgmt_pkg::*;

	logic          clock = 1'b0;
	logic          reset_n;
	logic          key_start_n;
	tpm_cc_t       tpm_cc;
	logic [32:0]   cmd_param;	// Enable handle above the yes/no bit
	logic [15:0]   orderly_input;
	logic          initialized;
	tpm_handle_t   auth_hierarchy;
	tpm_rc_t       execution_rc;
	logic [7:0]    locality;
	logic [15:0]   tests_run;
	logic [15:0]   tests_passed;
	logic [15:0]   untested;
	logic          nv_ph_enable_nv;
	logic          nv_sh_enable;
	logic          nv_eh_enable;
	op_state_e     op_state;
	startup_type_e startup_type;
	tpm_rc_t       tpm_rc;
	logic          ph_enable;
	logic          ph_enable_nv;
	logic          sh_enable;
	logic          eh_enable;
	logic [15:0]   shutdown_save;

	// Shadow copy of every register in the device
	op_state_e     m_state;
	startup_type_e m_type;
	tpm_rc_t       m_rc;
	logic          m_ph, m_phnv, m_sh, m_eh;
	logic          m_init_q;
	logic [15:0]   m_run_q, m_pass_q, m_untest_q;
	logic [15:0]   m_param_q, m_orderly_q;
	tpm_handle_t   m_auth, m_target;
	logic          m_yes;
	logic [15:0]   m_save;

	int          error_count = 0;
	int          timeout_count = 0;
	string       test_name = "reset";
	logic [31:0] rand_state = 32'd14;	// Seed of the xorshift sequence
	logic [31:0] rand_word;

	always #2 clock = ~clock;	// 4 ns period

	tpm_management #(.test_count_width(16)) dut (.*);

	//////////////////////////////////////////////////////////////////////
	// Random numbers and helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] next_random();
		rand_state = xorshift32(rand_state);
		return rand_state;
	endfunction

	function automatic tpm_handle_t pick_handle(input logic [2:0] idx);
		case (idx)
			3'd0: return rh_owner;
			3'd1: return rh_endorsement;
			3'd2: return rh_platform;
			3'd3: return rh_platform_nv;
			default: return 32'h4000_0007;	// Not a hierarchy
		endcase
	endfunction

	function automatic tpm_cc_t pick_cc(input logic [2:0] idx);
		case (idx)
			3'd0: return cc_hierarchy_control;
			3'd1: return cc_incremental_self_test;
			3'd2: return cc_self_test;
			3'd3: return cc_startup;
			3'd4: return cc_shutdown;
			3'd5: return cc_get_capability;
			3'd6: return cc_get_test_result;
			default: return 16'h0999;	// Unknown command
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model

	function void reset_model();
		m_state = power_off;
		m_type  = su_done;
		m_rc    = rc_success;
		{m_ph, m_phnv, m_sh, m_eh} = 4'b0000;
		m_init_q = 1'b0;
		{m_run_q, m_pass_q, m_untest_q} = '0;
		{m_auth, m_target, m_yes} = '0;
		m_save = su_clear;	// Parameter registers keep whatever they held
	endfunction

	function automatic void step_model();
		op_state_e     n_state;
		startup_type_e n_type;
		hc_verdict_e   v;
		logic          valid_start;
		n_state = m_state;
		n_type  = su_done;
		v       = hc_none;
		if (key_start_n)
			return;	// Frozen step
		if (m_state == operational && tpm_cc == cc_hierarchy_control && locality == 8'h01) begin
			if (m_auth == rh_platform)
				v = (m_target == rh_platform && m_yes) ? hc_value_error :
					(m_target == rh_platform || m_target == rh_owner ||
					m_target == rh_endorsement || m_target == rh_platform_nv) ?
					hc_success : hc_value_error;
			else if (m_auth == rh_owner || m_auth == rh_endorsement)
				v = (m_target == m_auth && !m_yes) ? hc_success : hc_auth_error;
		end
		case (m_state)
			power_off:      n_state = initialization;
			initialization: if (tpm_cc == cc_startup) n_state = startup;
			startup:        if (m_init_q) n_state = operational;
				else if (m_type == su_invalid) n_state = initialization;
			operational:    if (tpm_cc == cc_self_test || tpm_cc == cc_incremental_self_test)
					n_state = self_test;
				else if (tpm_cc == cc_shutdown) n_state = shutdown;
			self_test:      if (m_pass_q != m_run_q) n_state = failure_mode;
				else if (m_untest_q == 16'd0) n_state = operational;
			shutdown:       n_state = operational;
			default:        n_state = failure_mode;
		endcase
		if (m_state == startup)	// Orderly state shutdown is the only way to resume
			n_type = (m_orderly_q == 16'd1) ? ((m_param_q == 16'd1) ? su_resume : su_restart) :
				((m_param_q == 16'd1) ? su_invalid : su_reset);
		valid_start = (m_type == su_reset || m_type == su_restart || m_type == su_resume);
		case (m_state)
			initialization: if (tpm_cc != cc_startup) m_rc = rc_initialize;
			startup:        if (m_init_q) m_rc = rc_success;
				else if (m_type == su_invalid) m_rc = rc_value;
			operational:    m_rc = (v == hc_success) ? rc_success : (v == hc_value_error) ?
				rc_value : (v == hc_auth_error) ? rc_auth_type : execution_rc;
			self_test:      m_rc = (tests_passed != tests_run) ? rc_failure : execution_rc;
			failure_mode:   m_rc = (tpm_cc == cc_get_test_result || tpm_cc == cc_get_capability) ?
				execution_rc : rc_failure;
			default:        ;
		endcase
		if (m_state == startup && valid_start) begin
			m_ph = 1'b1;
			{m_phnv, m_sh, m_eh} = (m_type == su_resume) ?
				{nv_ph_enable_nv, nv_sh_enable, nv_eh_enable} : 3'b111;
		end else if (m_state == operational) begin
			if (v == hc_success) begin
				if (m_target == rh_endorsement) m_eh = m_yes;
				if (m_target == rh_owner) m_sh = m_yes;
				if (m_target == rh_platform_nv) m_phnv = m_yes;
				if (m_target == rh_platform) m_ph = m_yes;
			end
			{m_auth, m_target, m_yes} = {auth_hierarchy, cmd_param};	// Used on the next step
		end
		if (m_state == shutdown)
			m_save = cmd_param[15:0];
		{m_init_q, m_run_q, m_pass_q, m_untest_q} = {initialized, tests_run, tests_passed, untested};
		{m_param_q, m_orderly_q} = {cmd_param[15:0], orderly_input};
		m_state = n_state;
		m_type  = n_type;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Comparison

	task automatic show_error(input string sig, input logic [31:0] exp, input logic [31:0] act);
		error_count++;
		$display("** Error %s.%s expected %0h actual %0h", test_name, sig, exp, act);
	endtask

	task automatic compare_outputs();
		if (op_state !== m_state) show_error("op_state", m_state, op_state);
		if (startup_type !== m_type) show_error("startup_type", m_type, startup_type);
		if (tpm_rc !== m_rc) show_error("tpm_rc", m_rc, tpm_rc);
		if (ph_enable !== m_ph) show_error("ph_enable", m_ph, ph_enable);
		if (ph_enable_nv !== m_phnv) show_error("ph_enable_nv", m_phnv, ph_enable_nv);
		if (sh_enable !== m_sh) show_error("sh_enable", m_sh, sh_enable);
		if (eh_enable !== m_eh) show_error("eh_enable", m_eh, eh_enable);
		if (shutdown_save !== m_save) show_error("shutdown_save", m_save, shutdown_save);
	endtask

	// Inputs settle on the falling edge, so the model sees what the DUT saw
	always @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			reset_model();
		end else begin
			step_model();
			#1;
			compare_outputs();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks, each entered and left on a falling edge

	task automatic close_run();
		$display("Errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	task automatic drive(input tpm_cc_t cc, input logic [32:0] param);
		tpm_cc    = cc;
		cmd_param = param;
		@(negedge clock);
	endtask

	task automatic wait_for_state(input op_state_e target, input int limit);
		int cycles;
		cycles = 0;
		while (op_state !== target && cycles < limit) begin
			@(negedge clock);
			cycles++;
		end
		if (op_state !== target) begin
			timeout_count++;
			$display("Timeout in %s, op_state never reached %0d", test_name, target);
			close_run();
		end
	endtask

	task automatic apply_reset();
		key_start_n = 1'b1;
		reset_n     = 1'b0;
		initialized = 1'b0;
		repeat (2) @(negedge clock);
		reset_n = 1'b1;
		if (op_state !== power_off) show_error("reset_op_state", power_off, op_state);
		if (tpm_rc !== rc_success) show_error("reset_tpm_rc", rc_success, tpm_rc);
		drive(cc_startup, 33'd1);	// Frozen steps must leave every output alone
		drive(cc_shutdown, 33'd0);
		if (op_state !== power_off) show_error("frozen_op_state", power_off, op_state);
		key_start_n = 1'b0;
		drive(cc_get_capability, 33'd0);	// Power off to initialization
		drive(cc_get_capability, 33'd0);
		if (tpm_rc !== rc_initialize) show_error("init_rc", rc_initialize, tpm_rc);
	endtask

	task automatic run_startup(input logic [15:0] orderly, input logic [15:0] param,
			input startup_type_e expect_type);
		orderly_input = orderly;
		initialized   = 1'b0;
		drive(cc_startup, {17'd0, param});
		drive(cc_get_capability, {17'd0, param});
		if (startup_type !== expect_type) show_error("startup_type", expect_type, startup_type);
		if (expect_type == su_invalid) begin
			wait_for_state(initialization, 4);
			if (tpm_rc !== rc_value) show_error("invalid_rc", rc_value, tpm_rc);
		end else begin
			initialized = 1'b1;	// Engine ready, so startup completes
			wait_for_state(operational, 6);
		end
	endtask

	task automatic hier_cmd(input tpm_handle_t auth, input tpm_handle_t target, input logic yes,
			input logic [7:0] loc, input tpm_rc_t expect_rc);
		auth_hierarchy = auth;
		locality       = loc;
		drive(cc_hierarchy_control, {target, yes});	// Latches the arguments
		drive(cc_hierarchy_control, {target, yes});
		if (tpm_rc !== expect_rc) show_error("hier_rc", expect_rc, tpm_rc);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		{reset_n, key_start_n, initialized} = 3'b010;
		{tpm_cc, cmd_param, orderly_input} = '0;
		auth_hierarchy = '0;
		execution_rc   = 32'h0000_0922;
		locality       = locality_zero;
		{tests_run, tests_passed, untested} = '0;
		{nv_ph_enable_nv, nv_sh_enable, nv_eh_enable} = 3'b101;
		@(negedge clock);
		apply_reset();
		test_name = "startup_invalid";
		run_startup(su_clear, su_state, su_invalid);
		test_name = "startup_restart";
		run_startup(su_state, su_clear, su_restart);
		if ({ph_enable, ph_enable_nv, sh_enable, eh_enable} !== 4'b1111)
			show_error("restart_enables", 4'b1111, {ph_enable, ph_enable_nv, sh_enable, eh_enable});
		test_name = "startup_resume";
		apply_reset();
		run_startup(su_state, su_state, su_resume);
		if ({ph_enable, ph_enable_nv, sh_enable, eh_enable} !== 4'b1101)
			show_error("resume_enables", 4'b1101, {ph_enable, ph_enable_nv, sh_enable, eh_enable});
		test_name = "startup_reset";
		apply_reset();
		run_startup(su_clear, su_clear, su_reset);
		initialized = 1'b0;

		test_name = "hierarchy";
		hier_cmd(rh_platform, rh_owner, 1'b0, locality_zero, rc_success);
		hier_cmd(rh_platform, rh_owner, 1'b1, locality_zero, rc_success);
		hier_cmd(rh_platform, rh_platform, 1'b1, locality_zero, rc_value);
		hier_cmd(rh_owner, rh_owner, 1'b1, locality_zero, rc_auth_type);
		hier_cmd(rh_owner, rh_endorsement, 1'b0, locality_zero, rc_auth_type);
		hier_cmd(rh_owner, rh_owner, 1'b0, locality_zero, rc_success);
		hier_cmd(rh_endorsement, rh_endorsement, 1'b0, locality_zero, rc_success);
		hier_cmd(rh_platform, rh_platform_nv, 1'b0, locality_zero, rc_success);
		hier_cmd(rh_platform, rh_platform, 1'b0, 8'h04, execution_rc);	// Wrong locality
		hier_cmd(32'h4000_0007, rh_owner, 1'b0, locality_zero, execution_rc);
		hier_cmd(rh_platform, rh_platform, 1'b0, locality_zero, rc_success);

		// Random commands with equal counts so that self tests come back
		test_name = "random";
		repeat (60) begin
			key_start_n    = (next_random() % 8 == 0);
			auth_hierarchy = pick_handle(next_random() % 5);
			locality       = (next_random() % 4 == 0) ? 8'h04 : locality_zero;
			execution_rc   = next_random() & 32'h0000_0fff;
			rand_word      = next_random();
			tests_run      = rand_word[15:0];
			tests_passed   = tests_run;
			drive(pick_cc(next_random() % 8),
				{pick_handle(next_random() % 5), next_random() % 2 == 1});
		end
		key_start_n = 1'b0;
		wait_for_state(operational, 6);

		test_name = "self_test_pass";
		{tests_run, tests_passed, untested} = {16'd7, 16'd7, 16'd2};
		drive(cc_self_test, 33'd0);
		drive(cc_get_capability, 33'd0);
		if (op_state !== self_test) show_error("self_test_hold", self_test, op_state);
		untested = 16'd0;
		wait_for_state(operational, 4);

		test_name = "shutdown";
		drive(cc_shutdown, 33'd0);
		drive(cc_get_capability, {17'd0, su_state});	// Saved while in shutdown
		if (shutdown_save !== su_state) show_error("shutdown_save", su_state, shutdown_save);
		wait_for_state(operational, 2);

		test_name = "failure_mode";
		{tests_run, tests_passed} = {16'd5, 16'd4};
		drive(cc_incremental_self_test, 33'd0);
		wait_for_state(failure_mode, 4);
		execution_rc = 32'h0000_0333;
		drive(cc_get_test_result, 33'd0);
		if (tpm_rc !== execution_rc) show_error("get_test_result", execution_rc, tpm_rc);
		drive(cc_get_capability, 33'd0);
		if (tpm_rc !== execution_rc) show_error("get_capability", execution_rc, tpm_rc);
		drive(cc_hierarchy_control, 33'd0);
		if (tpm_rc !== rc_failure) show_error("blocked_cmd", rc_failure, tpm_rc);
		drive(cc_startup, 33'd0);
		close_run();
	end

endmodule

`default_nettype wire

//--- sources.f
common/tpm_mgmt_pkg.sv
hierarchy/hierarchy_control.sv
hw/op_state_fsm.sv
hw/startup_decoder.sv
hw/response_code_select.sv
hw/tpm_management.sv
verification/tpm_management_tb.sv

//--- Bender.yml
package:
  name: tpm_management

sources:
  - common/tpm_mgmt_pkg.sv
  - hierarchy/hierarchy_control.sv
  - hw/op_state_fsm.sv
  - hw/startup_decoder.sv
  - hw/response_code_select.sv
  - hw/tpm_management.sv
  - target: test
    files:
      - verification/tpm_management_tb.sv
